// ==== include/mmcCard_cfg.svh ====
// MMC card configuration
`ifndef MMC_CARD_CFG_SVH
`define MMC_CARD_CFG_SVH

// Bytes per block. Must be a power of two.
`define MMC_BLOCK_BYTES 16

// Number of blocks held by the card. Must be a power of two.
`define MMC_NUM_BLOCKS 4

// Rising clocks with chip select and data-in high that complete power-up.
`define MMC_POWERUP_CLKS 74

// Fill bytes of 0xFF sent before each R1.
`define MMC_NCR_BYTES 1

`endif

// ==== logic/mmcPkg.sv ====
// MMC card types and constants
package mmcPkg;

   // --------------------------------------------------
   // Command indices
   // --------------------------------------------------
   typedef enum logic [5:0] {
      cmdGoIdle      = 6'd0,
      cmdSendOpCond  = 6'd1,
      cmdSetBlockLen = 6'd16,
      cmdReadSingle  = 6'd17,
      cmdWriteSingle = 6'd24
   } cmdCodeT;

   // Operation that follows an accepted command.
   typedef enum logic [1:0] {
      opNone,
      opRead,
      opWrite
   } cardOpT;

   // Byte-slot states of the card sequencer.
   typedef enum logic [3:0] {
      seqIdle,
      seqRespDelay,
      seqReadGap,
      seqReadTok,
      seqReadData,
      seqReadCrc,
      seqWriteTok,
      seqWriteData,
      seqWriteCrc,
      seqWriteBusy,
      seqWriteDone
   } seqStateT;

   // --------------------------------------------------
   // R1 response bits and data tokens
   // --------------------------------------------------
   localparam logic [7:0] r1Idle          = 8'h01;
   localparam logic [7:0] r1Ready         = 8'h00;
   localparam logic [7:0] r1Illegal       = 8'h04;
   localparam logic [7:0] r1AddrError     = 8'h20;
   localparam logic [7:0] r1ParamError    = 8'h40;

   localparam logic [7:0] tokStart        = 8'hFE;
   localparam logic [7:0] tokDataAccepted = 8'h05;

endpackage

// ==== logic/spiByteShifter.sv ====
// SPI byte shifter
`include "mmcCard_cfg.svh"

module spiByteShifter (
   input  logic       spiClk,
   input  logic       rstN,
   input  logic       spiCsN,
   input  logic       spiDataIn,
   input  logic [7:0] txByte,
   output logic       spiDataOut,
   output logic [7:0] rxByte,
   output logic       rxValid,
   output logic       powerDone
);

   localparam int PowerW = $clog2(`MMC_POWERUP_CLKS);
   localparam logic [PowerW-1:0] PowerLast = PowerW'(`MMC_POWERUP_CLKS - 1);

   logic [2:0]        bitCnt;
   logic [6:0]        rxShift;
   logic [7:0]        txShift;
   logic [PowerW-1:0] powerCnt;

   // The MSB of the transmit register is always on the line.
   assign spiDataOut = txShift[7];

   always_ff @(posedge spiClk) begin
      if (!rstN) begin
         bitCnt    <= '0;
         txShift   <= 8'hFF;
         rxValid   <= 1'b0;
         powerCnt  <= '0;
         powerDone <= 1'b0;
      end else begin
         rxValid <= 1'b0;
         if (spiCsN) begin
            // Deselected. Framing restarts and MISO idles high.
            bitCnt  <= '0;
            txShift <= 8'hFF;
            if (spiDataIn && !powerDone) begin
               powerCnt <= powerCnt + 1'b1;
               if (powerCnt == PowerLast) begin
                  powerDone <= 1'b1;
               end
            end
         end else begin
            bitCnt  <= bitCnt + 3'd1;
            rxShift <= {rxShift[5:0], spiDataIn};
            if (bitCnt == 3'd7) begin
               rxByte  <= {rxShift, spiDataIn};
               rxValid <= 1'b1;
               txShift <= txByte;
            end else begin
               txShift <= {txShift[6:0], 1'b1};
            end
         end
      end
   end

endmodule

// ==== logic/cmdFramer.sv ====
// Command frame collector
module cmdFramer (
   input  logic            spiClk,
   input  logic            rstN,
   input  logic            rxValid,
   input  logic            powerDone,
   input  logic            storeReady,
   input  logic            dataPhase,
   input  logic [7:0]      rxByte,
   output logic            cmdValid,
   output mmcPkg::cmdCodeT cmdIndex,
   output logic [31:0]     cmdArg
);
   import mmcPkg::*;

   logic       enable;
   logic       inFrame;
   logic [2:0] byteCnt;

   assign enable = powerDone && storeReady && !dataPhase;

   always_ff @(posedge spiClk) begin
      if (!rstN) begin
         inFrame  <= 1'b0;
         byteCnt  <= '0;
         cmdValid <= 1'b0;
      end else begin
         cmdValid <= 1'b0;
         if (!enable) begin
            inFrame <= 1'b0;
         end else if (rxValid) begin
            if (!inFrame) begin
               // A start bit of 0 followed by the transmission bit opens a frame.
               if (rxByte[7:6] == 2'b01) begin
                  cmdIndex <= cmdCodeT'(rxByte[5:0]);
                  inFrame  <= 1'b1;
                  byteCnt  <= 3'd1;
               end
            end else if (byteCnt == 3'd5) begin
               // Sixth byte is the CRC, which is not checked.
               cmdValid <= 1'b1;
               inFrame  <= 1'b0;
            end else begin
               cmdArg  <= {cmdArg[23:0], rxByte};
               byteCnt <= byteCnt + 3'd1;
            end
         end
      end
   end

endmodule

// ==== logic/cmdDecoder.sv ====
// Command decoder
`include "mmcCard_cfg.svh"

module cmdDecoder (
   input  logic            spiClk,
   input  logic            rstN,
   input  logic            cmdValid,
   input  mmcPkg::cmdCodeT cmdIndex,
   input  logic [31:0]     cmdArg,
   output logic            respValid,
   output logic [7:0]      respByte,
   output mmcPkg::cardOpT  respOp,
   output logic [1:0]      respBlock
);
   import mmcPkg::*;

   localparam int OffW = $clog2(`MMC_BLOCK_BYTES);
   localparam logic [31:0] BlockBytes = 32'(`MMC_BLOCK_BYTES);
   localparam logic [31:0] StoreBytes = 32'(`MMC_NUM_BLOCKS * `MMC_BLOCK_BYTES);

   logic       idleFlag;
   logic       addrBad;
   logic [7:0] nextResp;
   cardOpT     nextOp;

   // Byte addresses must sit on a block boundary inside the store.
   assign addrBad = (cmdArg[OffW-1:0] != '0) || (cmdArg >= StoreBytes);

   always_comb begin
      nextOp = opNone;
      case (cmdIndex)
         cmdGoIdle: begin
            nextResp = r1Idle;
         end
         cmdSendOpCond: begin
            nextResp = r1Ready;
         end
         cmdSetBlockLen: begin
            nextResp = (cmdArg == BlockBytes) ? r1Ready : r1ParamError;
         end
         cmdReadSingle, cmdWriteSingle: begin
            if (idleFlag) begin
               nextResp = r1Illegal | r1Idle;
            end else if (addrBad) begin
               nextResp = r1AddrError;
            end else begin
               nextResp = r1Ready;
               nextOp   = (cmdIndex == cmdReadSingle) ? opRead : opWrite;
            end
         end
         default: begin
            nextResp = idleFlag ? (r1Illegal | r1Idle) : r1Illegal;
         end
      endcase
   end

   always_ff @(posedge spiClk) begin
      if (!rstN) begin
         idleFlag  <= 1'b1;
         respValid <= 1'b0;
      end else begin
         respValid <= cmdValid;
         if (cmdValid) begin
            respByte  <= nextResp;
            respOp    <= nextOp;
            respBlock <= cmdArg[OffW +: 2];
            if (cmdIndex == cmdGoIdle) begin
               idleFlag <= 1'b1;
            end else if (cmdIndex == cmdSendOpCond) begin
               idleFlag <= 1'b0;
            end
         end
      end
   end

endmodule

// ==== logic/cardSequencer.sv ====
// Card byte-slot sequencer
`include "mmcCard_cfg.svh"

module cardSequencer (
   input  logic           spiClk,
   input  logic           rstN,
   input  logic           rxValid,
   input  logic           respValid,
   input  logic [7:0]     rxByte,
   input  logic [7:0]     respByte,
   input  mmcPkg::cardOpT respOp,
   input  logic [1:0]     respBlock,
   input  logic [7:0]     rdData,
   output logic [7:0]     txByte,
   output logic           dataPhase,
   output logic           rdEn,
   output logic           wrEn,
   output logic [5:0]     rdAddr,
   output logic [5:0]     wrAddr,
   output logic [7:0]     wrData
);
   import mmcPkg::*;

   localparam int OffW = $clog2(`MMC_BLOCK_BYTES);
   localparam int CntW = $clog2(`MMC_BLOCK_BYTES + 9);
   localparam logic [CntW-1:0] LastData = CntW'(`MMC_BLOCK_BYTES - 1);
   localparam logic [CntW-1:0] NcrCount = CntW'(`MMC_NCR_BYTES);
   localparam logic [CntW-1:0] TokLast  = CntW'(7);
   localparam logic [CntW-1:0] PairLast = CntW'(1);

   seqStateT        state;
   logic [CntW-1:0] slotCnt;
   logic [7:0]      pendResp;
   cardOpT          pendOp;
   logic [1:0]      pendBlock;

   // Every byte chosen here goes out on the link one byte later.
   always_ff @(posedge spiClk) begin
      if (!rstN) begin
         state     <= seqIdle;
         slotCnt   <= '0;
         txByte    <= 8'hFF;
         dataPhase <= 1'b0;
         rdEn      <= 1'b0;
         wrEn      <= 1'b0;
      end else begin
         rdEn <= 1'b0;
         wrEn <= 1'b0;
         if (state == seqIdle) begin
            if (respValid) begin
               pendResp  <= respByte;
               pendOp    <= respOp;
               pendBlock <= respBlock;
               slotCnt   <= '0;
               state     <= seqRespDelay;
            end else if (rxValid) begin
               txByte <= 8'hFF;
            end
         end else if (rxValid) begin
            case (state)
               // --------------------------------------------------
               // Response
               // --------------------------------------------------
               seqRespDelay: begin
                  if (slotCnt == NcrCount) begin
                     txByte  <= pendResp;
                     slotCnt <= '0;
                     case (pendOp)
                        opRead: begin
                           dataPhase <= 1'b1;
                           state     <= seqReadGap;
                        end
                        opWrite: begin
                           dataPhase <= 1'b1;
                           state     <= seqWriteTok;
                        end
                        default: begin
                           state <= seqIdle;
                        end
                     endcase
                  end else begin
                     txByte  <= 8'hFF;
                     slotCnt <= slotCnt + 1'b1;
                  end
               end
               // --------------------------------------------------
               // Single block read
               // --------------------------------------------------
               seqReadGap: begin
                  txByte <= 8'hFF;
                  state  <= seqReadTok;
               end
               seqReadTok: begin
                  txByte  <= tokStart;
                  rdEn    <= 1'b1;
                  rdAddr  <= {pendBlock, {OffW{1'b0}}};
                  slotCnt <= '0;
                  state   <= seqReadData;
               end
               seqReadData: begin
                  // Store data arrived one cycle after the request.
                  txByte <= rdData;
                  if (slotCnt == LastData) begin
                     slotCnt <= '0;
                     state   <= seqReadCrc;
                  end else begin
                     rdEn    <= 1'b1;
                     rdAddr  <= rdAddr + 6'd1;
                     slotCnt <= slotCnt + 1'b1;
                  end
               end
               seqReadCrc: begin
                  txByte <= 8'hFF;
                  if (slotCnt == PairLast) begin
                     slotCnt   <= '0;
                     dataPhase <= 1'b0;
                     state     <= seqIdle;
                  end else begin
                     slotCnt <= slotCnt + 1'b1;
                  end
               end
               // --------------------------------------------------
               // Single block write
               // --------------------------------------------------
               seqWriteTok: begin
                  txByte <= 8'hFF;
                  if (rxByte == tokStart) begin
                     slotCnt <= '0;
                     state   <= seqWriteData;
                  end else if (slotCnt == TokLast) begin
                     // No start token within eight bytes, so the write is dropped.
                     slotCnt   <= '0;
                     dataPhase <= 1'b0;
                     state     <= seqIdle;
                  end else begin
                     slotCnt <= slotCnt + 1'b1;
                  end
               end
               seqWriteData: begin
                  wrEn   <= 1'b1;
                  wrAddr <= {pendBlock, slotCnt[OffW-1:0]};
                  wrData <= rxByte;
                  if (slotCnt == LastData) begin
                     slotCnt <= '0;
                     state   <= seqWriteCrc;
                  end else begin
                     slotCnt <= slotCnt + 1'b1;
                  end
               end
               seqWriteCrc: begin
                  if (slotCnt == PairLast) begin
                     txByte  <= tokDataAccepted;
                     slotCnt <= '0;
                     state   <= seqWriteBusy;
                  end else begin
                     slotCnt <= slotCnt + 1'b1;
                  end
               end
               seqWriteBusy: begin
                  txByte <= 8'h00;
                  if (slotCnt == PairLast) begin
                     slotCnt <= '0;
                     state   <= seqWriteDone;
                  end else begin
                     slotCnt <= slotCnt + 1'b1;
                  end
               end
               seqWriteDone: begin
                  txByte    <= 8'hFF;
                  dataPhase <= 1'b0;
                  state     <= seqIdle;
               end
               default: begin
                  state <= seqIdle;
               end
            endcase
         end
      end
   end

endmodule

// ==== logic/blockStore.sv ====
// Card block store
`include "mmcCard_cfg.svh"

module blockStore (
   input  logic       spiClk,
   input  logic       rstN,
   input  logic       rdEn,
   input  logic       wrEn,
   input  logic [5:0] rdAddr,
   input  logic [5:0] wrAddr,
   input  logic [7:0] wrData,
   output logic [7:0] rdData,
   output logic       storeReady
);

   localparam int Depth = `MMC_NUM_BLOCKS * `MMC_BLOCK_BYTES;
   localparam logic [5:0] FillLast = 6'(Depth - 1);

   logic [7:0] mem [Depth];
   logic [5:0] fillAddr;

   // Pattern fill walks the store once after reset.
   always_ff @(posedge spiClk) begin
      if (!rstN) begin
         fillAddr   <= '0;
         storeReady <= 1'b0;
      end else if (!storeReady) begin
         fillAddr <= fillAddr + 6'd1;
         if (fillAddr == FillLast) begin
            storeReady <= 1'b1;
         end
      end
   end

   always_ff @(posedge spiClk) begin
      if (!storeReady) begin
         mem[fillAddr] <= 8'(fillAddr);
      end else if (wrEn) begin
         mem[wrAddr] <= wrData;
      end
      if (rdEn) begin
         rdData <= mem[rdAddr];
      end
   end

endmodule

// ==== logic/mmcCard.sv ====
// MMC card top level
module mmcCard (
   input  logic spiClk,
   input  logic rstN,
   input  logic spiCsN,
   input  logic spiDataIn,
   output logic spiDataOut
);
   import mmcPkg::*;

   logic [7:0]  txByte;
   logic [7:0]  rxByte;
   logic        rxValid;
   logic        powerDone;
   logic        cmdValid;
   cmdCodeT     cmdIndex;
   logic [31:0] cmdArg;
   logic        respValid;
   logic [7:0]  respByte;
   cardOpT      respOp;
   logic [1:0]  respBlock;
   logic        dataPhase;
   logic        rdEn;
   logic        wrEn;
   logic [5:0]  rdAddr;
   logic [5:0]  wrAddr;
   logic [7:0]  wrData;
   logic [7:0]  rdData;
   logic        storeReady;

   spiByteShifter spiByteShifter_inst (
      .spiClk     (spiClk),
      .rstN       (rstN),
      .spiCsN     (spiCsN),
      .spiDataIn  (spiDataIn),
      .txByte     (txByte),
      .spiDataOut (spiDataOut),
      .rxByte     (rxByte),
      .rxValid    (rxValid),
      .powerDone  (powerDone)
   );

   cmdFramer cmdFramer_inst (
      .spiClk     (spiClk),
      .rstN       (rstN),
      .rxValid    (rxValid),
      .powerDone  (powerDone),
      .storeReady (storeReady),
      .dataPhase  (dataPhase),
      .rxByte     (rxByte),
      .cmdValid   (cmdValid),
      .cmdIndex   (cmdIndex),
      .cmdArg     (cmdArg)
   );

   cmdDecoder cmdDecoder_inst (
      .spiClk    (spiClk),
      .rstN      (rstN),
      .cmdValid  (cmdValid),
      .cmdIndex  (cmdIndex),
      .cmdArg    (cmdArg),
      .respValid (respValid),
      .respByte  (respByte),
      .respOp    (respOp),
      .respBlock (respBlock)
   );

   cardSequencer cardSequencer_inst (
      .spiClk    (spiClk),
      .rstN      (rstN),
      .rxValid   (rxValid),
      .respValid (respValid),
      .rxByte    (rxByte),
      .respByte  (respByte),
      .respOp    (respOp),
      .respBlock (respBlock),
      .rdData    (rdData),
      .txByte    (txByte),
      .dataPhase (dataPhase),
      .rdEn      (rdEn),
      .wrEn      (wrEn),
      .rdAddr    (rdAddr),
      .wrAddr    (wrAddr),
      .wrData    (wrData)
   );

   blockStore blockStore_inst (
      .spiClk     (spiClk),
      .rstN       (rstN),
      .rdEn       (rdEn),
      .wrEn       (wrEn),
      .rdAddr     (rdAddr),
      .wrAddr     (wrAddr),
      .wrData     (wrData),
      .rdData     (rdData),
      .storeReady (storeReady)
   );

endmodule

// ==== verif/mmcCardTb.sv ====
// MMC card testbench
`include "mmcCard_cfg.svh"

module mmcCardTb;
   timeunit 1ns;
   timeprecision 100ps;
   import mmcPkg::*;

   localparam int BlockBytes = `MMC_BLOCK_BYTES;
   localparam int NumBlocks  = `MMC_NUM_BLOCKS;

   logic       spiClk = 1'b0;
   logic       rstN;
   logic       spiCsN;
   logic       spiDataIn;
   logic       spiDataOut;
   logic [31:0] rngState;
   logic [7:0] readBuf [BlockBytes];
   logic [7:0] writeBuf [BlockBytes];

   mmcCard mmcCard_inst (
      .spiClk     (spiClk),
      .rstN       (rstN),
      .spiCsN     (spiCsN),
      .spiDataIn  (spiDataIn),
      .spiDataOut (spiDataOut)
   );

   always #20 spiClk = ~spiClk;

   // --------------------------------------------------
   // Checking and random data
   // --------------------------------------------------
   task automatic failRun(input string reason);
      $display("%s", reason);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic checkEq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
      if (actual !== expected) begin
         failRun($sformatf("FAIL at %0d ns: %s is 0x%0h, expected 0x%0h",
                           $time, name, actual, expected));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // --------------------------------------------------
   // SPI host model
   // --------------------------------------------------
   // MOSI changes on the rising edge, and MISO is read in the low half of the clock.
   task automatic hostByte(input logic [7:0] txVal, output logic [7:0] rxVal);
      for (int i = 7; i >= 0; i--) begin
         @(posedge spiClk);
         spiCsN    <= 1'b0;
         spiDataIn <= txVal[i];
         @(negedge spiClk);
         rxVal[i] = spiDataOut;
      end
   endtask

   task automatic sendClocks(input int count);
      repeat (count) begin
         @(posedge spiClk);
         spiCsN    <= 1'b1;
         spiDataIn <= 1'b1;
      end
   endtask

   // Deselected clocks with data-in low do not count toward power-up.
   task automatic idleLowClocks(input int count);
      repeat (count) begin
         @(posedge spiClk);
         spiCsN    <= 1'b1;
         spiDataIn <= 1'b0;
      end
   endtask

   task automatic sendCmd(input logic [5:0] index, input logic [31:0] arg);
      logic [7:0] ignored;
      hostByte({2'b01, index}, ignored);
      for (int i = 3; i >= 0; i--) begin
         hostByte(arg[8*i +: 8], ignored);
      end
      hostByte(8'hFF, ignored);
   endtask

   // Clocks out idle bytes until the card sends something other than 0xFF.
   task automatic pollByte(input int limit, output logic [7:0] value, output logic found);
      found = 1'b0;
      value = 8'hFF;
      for (int i = 0; i < limit && !found; i++) begin
         hostByte(8'hFF, value);
         found = (value != 8'hFF);
      end
   endtask

   task automatic getR1(output logic [7:0] r1);
      logic found;
      pollByte(8, r1, found);
      if (!found) begin
         failRun("The card sent no R1 response within 8 bytes.");
      end
   endtask

   task automatic waitToken();
      logic [7:0] tok;
      logic       found;
      pollByte(16, tok, found);
      if (!found) begin
         failRun("The card sent no data token within 16 bytes.");
      end
      checkEq("read token", tok, tokStart);
   endtask

   task automatic issueCommand(input logic [5:0] index, input logic [31:0] arg,
                               input logic [7:0] expR1, input string name);
      logic [7:0] r1;
      sendCmd(index, arg);
      getR1(r1);
      checkEq(name, r1, expR1);
   endtask

   task automatic readBlock(input int blk);
      logic [7:0] crc;
      issueCommand(cmdReadSingle, blk * BlockBytes, r1Ready, "R1 of CMD17");
      waitToken();
      for (int k = 0; k < BlockBytes; k++) begin
         hostByte(8'hFF, readBuf[k]);
      end
      for (int i = 0; i < 2; i++) begin
         hostByte(8'hFF, crc);
         checkEq("read CRC byte", crc, 8'hFF);
      end
   endtask

   // --------------------------------------------------
   // Directed tests
   // --------------------------------------------------
   task automatic testPowerup();
      logic [7:0] resp;
      logic       found;
      // The store fill is over first, so only the power-up count can keep the card silent.
      idleLowClocks(NumBlocks * BlockBytes + 4);
      sendClocks(20);
      sendCmd(cmdGoIdle, 32'h0);
      pollByte(8, resp, found);
      if (found) begin
         failRun("The card answered CMD0 before power-up had completed.");
      end
      sendClocks(`MMC_POWERUP_CLKS + 6);
      issueCommand(cmdGoIdle, 32'h0, r1Idle, "R1 of CMD0");
   endtask

   task automatic testInit();
      issueCommand(cmdReadSingle, 32'h0, r1Illegal | r1Idle, "R1 of CMD17 while idle");
      issueCommand(6'd55, 32'h0, r1Illegal | r1Idle, "R1 of CMD55 while idle");
      issueCommand(cmdSendOpCond, 32'h0, r1Ready, "R1 of CMD1");
      issueCommand(6'd55, 32'h0, r1Illegal, "R1 of CMD55 when ready");
   endtask

   task automatic testBlockLen();
      issueCommand(cmdSetBlockLen, BlockBytes, r1Ready, "R1 of CMD16");
      issueCommand(cmdSetBlockLen, 32'd512, r1ParamError, "R1 of CMD16 at 512");
      issueCommand(cmdReadSingle, 32'd3, r1AddrError, "R1 of unaligned CMD17");
      issueCommand(cmdReadSingle, NumBlocks * BlockBytes, r1AddrError,
                   "R1 of out-of-range CMD17");
   endtask

   task automatic testRead();
      readBlock(2);
      for (int k = 0; k < BlockBytes; k++) begin
         checkEq($sformatf("block 2 byte %0d", k), readBuf[k], (2 * BlockBytes + k) % 256);
      end
   endtask

   task automatic testWriteReadBack();
      logic [7:0] rx;
      logic       found;
      for (int k = 0; k < BlockBytes; k++) begin
         rngState    = xorshift32(rngState);
         writeBuf[k] = rngState[7:0];
      end
      issueCommand(cmdWriteSingle, BlockBytes, r1Ready, "R1 of CMD24");
      hostByte(8'hFF, rx);
      hostByte(tokStart, rx);
      for (int k = 0; k < BlockBytes; k++) begin
         hostByte(writeBuf[k], rx);
      end
      hostByte(8'hFF, rx);
      hostByte(8'hFF, rx);
      pollByte(8, rx, found);
      if (!found) begin
         failRun("The card sent no data response within 8 bytes.");
      end
      checkEq("data response", rx, tokDataAccepted);
      hostByte(8'hFF, rx);
      checkEq("busy byte", rx, 8'h00);
      // Busy ends when the line returns to 0xFF.
      found = 1'b0;
      for (int i = 0; i < 8 && !found; i++) begin
         hostByte(8'hFF, rx);
         found = (rx == 8'hFF);
         if (!found) begin
            checkEq("busy byte", rx, 8'h00);
         end
      end
      if (!found) begin
         failRun("The card stayed busy for more than 8 bytes after the write.");
      end
      readBlock(1);
      for (int k = 0; k < BlockBytes; k++) begin
         checkEq($sformatf("block 1 byte %0d", k), readBuf[k], writeBuf[k]);
      end
      readBlock(0);
      for (int k = 0; k < BlockBytes; k++) begin
         checkEq($sformatf("block 0 byte %0d", k), readBuf[k], k % 256);
      end
   endtask

   initial begin
      rngState  = 32'hd239;
      rstN      <= 1'b0;
      spiCsN    <= 1'b1;
      spiDataIn <= 1'b1;
      repeat (2) @(posedge spiClk);
      rstN <= 1'b1;
      testPowerup();
      testInit();
      testBlockLen();
      testRead();
      testWriteReadBack();
      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== mmcCard.f ====
+incdir+include
logic/mmcPkg.sv
logic/spiByteShifter.sv
logic/cmdFramer.sv
logic/cmdDecoder.sv
logic/cardSequencer.sv
logic/blockStore.sv
logic/mmcCard.sv
verif/mmcCardTb.sv

// ==== Bender.yml ====
package:
  name: mmcCard

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/mmcPkg.sv
      - logic/spiByteShifter.sv
      - logic/cmdFramer.sv
      - logic/cmdDecoder.sv
      - logic/cardSequencer.sv
      - logic/blockStore.sv
      - logic/mmcCard.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/mmcCardTb.sv
